/* cpu_top.f */
+incdir+src
src/cpu_pkg.sv
src/ctrl_if.sv
src/control_unit.sv
src/alu.sv
src/reg_file.sv
src/data_mem.sv
src/datapath.sv
src/cpu_top.sv
verif/tb_clock.sv
verif/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cpu testbench with verilator, run it, and fail if the log holds a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module cpu_tb -f cpu_top.f -o cpu_sim \
  && ./obj_dir/cpu_sim > sim.log 2>&1 \
  || { echo "simulation build or run did not complete"; exit 1; }
cat sim.log
grep -q '>>> FAIL' sim.log && exit 1
exit 0

/* src/alu.sv */
// alu: add, subtract, unsigned greater-than and equality on 16-bit words
`include "cpu_params.svh"

module alu import cpu_pkg::*; (
  input  logic [`CPU_XLEN-1:0] a,
  input  logic [`CPU_XLEN-1:0] b,
  input  alu_op_t              op,
  output logic [`CPU_XLEN-1:0] y
);

  always_comb begin
    case (op)
      alu_add: begin
        y = a + b; // wraps at 16 bits
      end
      alu_sub: begin
        y = a - b;
      end
      alu_grt: begin
        y = {{(`CPU_XLEN-1){1'b0}}, (a > b)}; // unsigned compare
      end
      alu_eq: begin
        y = {{(`CPU_XLEN-1){1'b0}}, (a == b)};
      end
      default: begin
        y = a + b;
      end
    endcase
  end

endmodule

/* src/control_unit.sv */
// opcode decoder: maps the 4-bit opcode to the datapath control levels
module control_unit import cpu_pkg::*; (
  input logic     reset,
  ctrl_if.decoder ctrl
);

  always_comb begin
    // everything off unless the opcode turns it on
    ctrl.imm_sel   = imm_low4;
    ctrl.alu_op    = alu_add;
    ctrl.in1_pc    = 1'b0;
    ctrl.in2_sel   = in2_reg;
    ctrl.mem_write = 1'b0;
    ctrl.reg_write = 1'b0;
    ctrl.wb_sel    = wb_alu;
    ctrl.jump      = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.port_wr   = 1'b0;
    ctrl.port_rd   = 1'b0;

    if (!reset) begin
      case (ctrl.opcode)
        op_add: begin
          ctrl.reg_write = 1'b1;
        end
        op_sub: begin
          ctrl.alu_op    = alu_sub;
          ctrl.reg_write = 1'b1;
        end
        op_grt: begin
          ctrl.alu_op    = alu_grt;
          ctrl.reg_write = 1'b1;
        end
        op_eq: begin
          ctrl.alu_op    = alu_eq;
          ctrl.reg_write = 1'b1;
        end
        op_addi: begin
          ctrl.in2_sel   = in2_imm;
          ctrl.reg_write = 1'b1;
        end
        op_lui: begin
          ctrl.imm_sel   = imm_upper; // datapath adds it to r0
          ctrl.in2_sel   = in2_imm;
          ctrl.reg_write = 1'b1;
        end
        op_lw: begin
          ctrl.in2_sel   = in2_imm;
          ctrl.wb_sel    = wb_mem;
          ctrl.reg_write = 1'b1;
        end
        op_sw: begin
          ctrl.in2_sel   = in2_imm;
          ctrl.mem_write = 1'b1;
        end
        op_jal: begin
          ctrl.imm_sel   = imm_low8;
          ctrl.in1_pc    = 1'b1; // alu forms pc + 1
          ctrl.in2_sel   = in2_one;
          ctrl.jump      = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        op_jalr: begin
          ctrl.in2_sel = in2_imm; // target is b + imm
          ctrl.jump    = 1'b1;
        end
        op_bne: begin
          ctrl.alu_op = alu_eq; // taken when the compare is 0
          ctrl.branch = 1'b1;
        end
        op_wri: begin
          ctrl.port_wr = 1'b1;
        end
        default: begin // rea and unused codes
          ctrl.wb_sel    = wb_port;
          ctrl.reg_write = 1'b1;
          ctrl.port_rd   = 1'b1;
        end
      endcase
    end
  end

endmodule

/* src/cpu_params.svh */
// cpu parameters: word width, register count and memory sizes
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and instruction width
`define CPU_XLEN 16

`define CPU_REGS 16 // architectural registers

// word-addressed memories
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

`define CPU_AW 8 // pc and memory address bits

`endif

/* src/cpu_pkg.sv */
// cpu package: opcode and datapath select types shared by decoder and datapath
package cpu_pkg;

  typedef enum logic [3:0] {
    op_add  = 4'b0000,
    op_grt  = 4'b0001,
    op_sub  = 4'b0010,
    op_eq   = 4'b0011,
    op_jalr = 4'b0100,
    op_lui  = 4'b0101,
    op_jal  = 4'b0110,
    op_addi = 4'b1000,
    op_lw   = 4'b1001,
    op_sw   = 4'b1010,
    op_bne  = 4'b1011,
    op_wri  = 4'b1100,
    op_rea  = 4'b1111
  } opcode_t;

  typedef enum logic [1:0] {
    imm_low4  = 2'b00, // sext bits 3:0
    imm_low8  = 2'b01, // sext bits 7:0
    imm_upper = 2'b10  // bits 7:0 in upper byte
  } imm_sel_t;

  typedef enum logic [1:0] {
    alu_add = 2'b00,
    alu_sub = 2'b01,
    alu_grt = 2'b10,
    alu_eq  = 2'b11
  } alu_op_t;

  typedef enum logic [1:0] {
    in2_reg = 2'b00,
    in2_one = 2'b01, // link value pc + 1
    in2_imm = 2'b10
  } in2_sel_t;

  typedef enum logic [1:0] {
    wb_alu  = 2'b00,
    wb_mem  = 2'b01,
    wb_port = 2'b10
  } wb_sel_t;

endpackage

/* src/cpu_top.sv */
// cpu top: opcode decoder and datapath joined through the control interface
`include "cpu_params.svh"

module cpu_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 imem_we,
  input  logic [`CPU_AW-1:0]   imem_addr,
  input  logic [`CPU_XLEN-1:0] imem_wdata,
  input  logic [`CPU_XLEN-1:0] port_in,
  output logic [`CPU_XLEN-1:0] port_out,
  output logic                 port_wr_strobe,
  output logic                 port_rd_strobe,
  output logic [`CPU_AW-1:0]   pc
);

  ctrl_if ctrl ();

  control_unit u_ctrl (
    .reset (reset),
    .ctrl  (ctrl)
  );

  datapath u_dp (
    .clk            (clk),
    .reset          (reset),
    .imem_we        (imem_we),
    .imem_addr      (imem_addr),
    .imem_wdata     (imem_wdata),
    .port_in        (port_in),
    .ctrl           (ctrl),
    .port_out       (port_out),
    .port_wr_strobe (port_wr_strobe),
    .port_rd_strobe (port_rd_strobe),
    .pc             (pc)
  );

endmodule

/* src/ctrl_if.sv */
// control interface: decoded control levels from the opcode decoder to the datapath
interface ctrl_if import cpu_pkg::*; ();

  opcode_t  opcode;
  imm_sel_t imm_sel;
  alu_op_t  alu_op;
  logic     in1_pc; // pc as first alu operand
  in2_sel_t in2_sel;
  logic     mem_write;
  logic     reg_write;
  wb_sel_t  wb_sel;
  logic     jump;
  logic     branch;
  logic     port_wr;
  logic     port_rd;

  modport decoder (
    input  opcode,
    output imm_sel, alu_op, in1_pc, in2_sel, mem_write, reg_write, wb_sel,
           jump, branch, port_wr, port_rd
  );

  modport datapath (
    output opcode,
    input  imm_sel, alu_op, in1_pc, in2_sel, mem_write, reg_write, wb_sel,
           jump, branch, port_wr, port_rd
  );

endinterface

/* src/data_mem.sv */
// data memory: word array with synchronous write and combinational read
`include "cpu_params.svh"

module data_mem (
  input  logic                 clk,
  input  logic                 we,
  input  logic [`CPU_AW-1:0]   addr,
  input  logic [`CPU_XLEN-1:0] wd,
  output logic [`CPU_XLEN-1:0] rd
);

  logic [`CPU_XLEN-1:0] mem [`CPU_DMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wd;
    end
  end

  assign rd = mem[addr]; // same-cycle read for lw

endmodule

/* src/datapath.sv */
// datapath: pc, instruction memory, immediates, alu operands, next pc, write-back and port i/o
`include "cpu_params.svh"

module datapath import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 imem_we,
  input  logic [`CPU_AW-1:0]   imem_addr,
  input  logic [`CPU_XLEN-1:0] imem_wdata,
  input  logic [`CPU_XLEN-1:0] port_in,
  ctrl_if.datapath             ctrl,
  output logic [`CPU_XLEN-1:0] port_out,
  output logic                 port_wr_strobe,
  output logic                 port_rd_strobe,
  output logic [`CPU_AW-1:0]   pc
);

  logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_DEPTH];
  logic [`CPU_XLEN-1:0] instr;
  logic [3:0]           field_a;
  logic [3:0]           field_b;
  logic [3:0]           field_c;
  logic [`CPU_XLEN-1:0] imm;
  logic [3:0]           ra1;
  logic [3:0]           ra2;
  logic [`CPU_XLEN-1:0] rd1;
  logic [`CPU_XLEN-1:0] rd2;
  logic [`CPU_XLEN-1:0] alu_a;
  logic [`CPU_XLEN-1:0] alu_b;
  logic [`CPU_XLEN-1:0] alu_y;
  logic [`CPU_XLEN-1:0] mem_rd;
  logic [`CPU_XLEN-1:0] wb_data;
  logic [`CPU_AW-1:0]   pc_target;
  logic [`CPU_AW-1:0]   pc_next;

  // loader port, usable at any time
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  assign instr       = imem[pc];
  assign ctrl.opcode = opcode_t'(instr[15:12]);
  assign field_a     = instr[11:8];
  assign field_b     = instr[7:4];
  assign field_c     = instr[3:0];

  always_comb begin
    case (ctrl.imm_sel)
      imm_low8:  imm = {{(`CPU_XLEN-8){instr[7]}}, instr[7:0]};
      imm_upper: imm = {instr[7:0], 8'h00};
      default:   imm = {{(`CPU_XLEN-4){instr[3]}}, instr[3:0]};
    endcase
  end

  assign ra1 = (ctrl.imm_sel == imm_upper) ? 4'd0 : field_b; // lui adds to r0
  assign ra2 = (ctrl.mem_write || ctrl.branch) ? field_a : field_c; // sw data, bne compare

  reg_file u_regs (
    .clk   (clk),
    .reset (reset),
    .we    (ctrl.reg_write),
    .ra1   (ra1),
    .ra2   (ra2),
    .wa    (field_a),
    .wd    (wb_data),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  assign alu_a = ctrl.in1_pc ? {{(`CPU_XLEN-`CPU_AW){1'b0}}, pc} : rd1;

  always_comb begin
    case (ctrl.in2_sel)
      in2_one: alu_b = `CPU_XLEN'(1);
      in2_imm: alu_b = imm;
      default: alu_b = rd2;
    endcase
  end

  alu u_alu (
    .a  (alu_a),
    .b  (alu_b),
    .op (ctrl.alu_op),
    .y  (alu_y)
  );

  data_mem u_dmem (
    .clk  (clk),
    .we   (ctrl.mem_write),
    .addr (alu_y[`CPU_AW-1:0]),
    .wd   (rd2),
    .rd   (mem_rd)
  );

  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  wb_data = mem_rd;
      wb_port: wb_data = port_in;
      default: wb_data = alu_y;
    endcase
  end

  assign pc_target = pc + imm[`CPU_AW-1:0]; // jal and bne offset

  always_comb begin
    pc_next = pc + `CPU_AW'(1);
    if (ctrl.jump) begin
      pc_next = ctrl.in1_pc ? pc_target : alu_y[`CPU_AW-1:0]; // jal : jalr
    end else if (ctrl.branch && (alu_y == '0)) begin
      pc_next = pc_target;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc             <= '0;
      port_out       <= '0;
      port_wr_strobe <= 1'b0;
    end else begin
      pc             <= pc_next;
      port_wr_strobe <= ctrl.port_wr;
      if (ctrl.port_wr) begin
        port_out <= rd1; // wri sends b
      end
    end
  end

  assign port_rd_strobe = ctrl.port_rd;

endmodule

/* src/reg_file.sv */
// register file: 16 x 16-bit, two asynchronous reads, one synchronous write, r0 fixed at zero
`include "cpu_params.svh"

module reg_file (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 we,
  input  logic [3:0]           ra1,
  input  logic [3:0]           ra2,
  input  logic [3:0]           wa,
  input  logic [`CPU_XLEN-1:0] wd,
  output logic [`CPU_XLEN-1:0] rd1,
  output logic [`CPU_XLEN-1:0] rd2
);

  logic [`CPU_XLEN-1:0] regs [`CPU_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != 4'd0)) begin // r0 ignores writes
      regs[wa] <= wd;
    end
  end

  // r0 reads zero regardless of contents
  assign rd1 = (ra1 == 4'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 4'd0) ? '0 : regs[ra2];

endmodule

/* verif/cpu_tb.sv */
// cpu testbench: loads table programs, answers the input port and checks every port write
`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          n_rows         = 12;
  localparam int          timeout_cycles = 200;
  localparam logic [15:0] nop_word       = 16'h0000; // add r0, r0, r0
  localparam logic [15:0] halt_word      = 16'h6000; // jal r0, 0 spins in place

  logic               clk;
  logic               reset;
  logic               imem_we;
  logic [`CPU_AW-1:0] imem_addr;
  logic [15:0]        imem_wdata;
  logic [15:0]        port_in;
  logic [15:0]        port_out;
  logic               port_wr_strobe;
  logic               port_rd_strobe;
  logic [`CPU_AW-1:0] pc;

  string       names   [n_rows];
  logic [15:0] prog    [n_rows][8];
  logic [15:0] pin     [n_rows][2];
  logic [15:0] exp_out [n_rows][4];
  int          n_in    [n_rows];
  int          n_exp   [n_rows];
  integer      seed = 32'hd766;
  int          errors;
  int          timeouts;

  tb_clock u_clk (.clk(clk));

  cpu_top dut (
    .clk            (clk),
    .reset          (reset),
    .imem_we        (imem_we),
    .imem_addr      (imem_addr),
    .imem_wdata     (imem_wdata),
    .port_in        (port_in),
    .port_out       (port_out),
    .port_wr_strobe (port_wr_strobe),
    .port_rd_strobe (port_rd_strobe),
    .pc             (pc)
  );

  function automatic logic [15:0] encode(input logic [3:0] op, input int a, input int b,
                                         input int c);
    return {op, a[3:0], b[3:0], c[3:0]};
  endfunction

  function automatic logic [15:0] encode_imm8(input logic [3:0] op, input int a, input int imm);
    return {op, a[3:0], imm[7:0]};
  endfunction

  // two port reads, one operation, then result and both operands written out
  task automatic set_regop_row(input int r, input string name, input logic [3:0] op,
                               input int dst, input logic [15:0] a, input logic [15:0] b,
                               input logic [15:0] result);
    names[r]   = name;
    prog[r]    = '{nop_word, encode(op_rea, 1, 0, 0), encode(op_rea, 2, 0, 0),
                   encode(op, dst, 1, 2), encode(op_wri, 0, dst, 0), encode(op_wri, 0, 1, 0),
                   encode(op_wri, 0, 2, 0), halt_word};
    pin[r]     = '{a, b};
    n_in[r]    = 2;
    exp_out[r] = '{result, a, b, 16'h0};
    n_exp[r]   = 3;
  endtask

  task automatic build_table();
    logic [15:0] a;
    logic [15:0] b;
    for (int r = 0; r < n_rows; r++) begin
      pin[r]     = '{default: 16'h0};
      exp_out[r] = '{default: 16'h0};
      n_in[r]    = 0;
    end
    a = 16'($random(seed));
    b = 16'($random(seed));
    set_regop_row(0, "add", op_add, 3, a, b, a + b);
    a = 16'($random(seed));
    b = 16'($random(seed));
    set_regop_row(1, "sub", op_sub, 3, a, b, a - b);
    a = 16'($random(seed));
    b = 16'($random(seed));
    set_regop_row(2, "grt", op_grt, 3, a, b, {15'd0, a > b});
    a = 16'($random(seed));
    b = a; // equal operands give 1
    set_regop_row(3, "eq", op_eq, 3, a, b, {15'd0, a == b});
    a = 16'($random(seed));
    b = 16'($random(seed));
    set_regop_row(4, "r0", op_add, 0, a, b, 16'h0); // r0 stays zero
    names[5]   = "imm";
    prog[5]    = '{nop_word, encode(op_addi, 1, 0, -3), encode(op_wri, 0, 1, 0),
                   encode(op_addi, 2, 1, 7), encode(op_wri, 0, 2, 0),
                   encode_imm8(op_lui, 3, 'ha5), encode(op_wri, 0, 3, 0), halt_word};
    exp_out[5] = '{16'(-3), 16'(-3) + 16'd7, {8'ha5, 8'h00}, 16'h0};
    n_exp[5]   = 3;
    a = 16'($random(seed));
    names[6]   = "mem"; // base 6: word 8 gets the port value, word 9 gets 6
    prog[6]    = '{nop_word, encode(op_rea, 1, 0, 0), encode(op_addi, 3, 0, 6),
                   encode(op_sw, 1, 3, 2), encode(op_sw, 3, 3, 3), encode(op_lw, 4, 3, 2),
                   encode(op_wri, 0, 4, 0), halt_word};
    pin[6][0]  = a;
    n_in[6]    = 1;
    exp_out[6][0] = a;
    n_exp[6]   = 1;
    names[7]   = "mem_keep"; // base 4 reads words 9 and 8 back
    prog[7]    = '{nop_word, encode(op_addi, 2, 0, 4), encode(op_lw, 1, 2, 5),
                   encode(op_wri, 0, 1, 0), encode(op_lw, 3, 2, 4), encode(op_wri, 0, 3, 0),
                   halt_word, halt_word};
    exp_out[7] = '{16'd6, a, 16'h0, 16'h0};
    n_exp[7]   = 2;
    a = 16'($random(seed)) | 16'h0100; // nonzero so bne against r0 is taken
    names[8]   = "bne";
    prog[8]    = '{nop_word, encode(op_rea, 1, 0, 0), encode(op_bne, 1, 0, 2),
                   encode(op_wri, 0, 0, 0), encode(op_wri, 0, 1, 0), encode(op_bne, 1, 1, 2),
                   encode(op_wri, 0, 0, 0), halt_word};
    pin[8][0]  = a;
    n_in[8]    = 1;
    exp_out[8] = '{a, 16'h0, 16'h0, 16'h0};
    n_exp[8]   = 2;
    names[9]   = "jal"; // jal at address 2 links 3 and lands on 5
    prog[9]    = '{nop_word, nop_word, encode_imm8(op_jal, 5, 3), encode(op_wri, 0, 0, 0),
                   halt_word, encode(op_wri, 0, 5, 0), halt_word, halt_word};
    exp_out[9][0] = 16'd3;
    n_exp[9]   = 1;
    names[10]  = "jalr"; // target r1 + 2 = 5
    prog[10]   = '{nop_word, encode(op_addi, 1, 0, 3), encode(op_jalr, 0, 1, 2),
                   encode(op_addi, 2, 0, 7), encode(op_wri, 0, 2, 0),
                   encode(op_addi, 3, 0, -6), encode(op_wri, 0, 3, 0), halt_word};
    exp_out[10][0] = 16'(-6);
    n_exp[10]  = 1;
    a = 16'($random(seed));
    names[11]  = "unknown_op";
    prog[11]   = '{nop_word, encode(4'b1110, 6, 0, 0), encode(op_wri, 0, 6, 0),
                   halt_word, halt_word, halt_word, halt_word, halt_word};
    pin[11][0] = a;
    n_in[11]   = 1;
    exp_out[11][0] = a;
    n_exp[11]  = 1;
  endtask

  task automatic check_idle(input string tag);
    if (pc !== '0 || port_wr_strobe !== 1'b0 || port_rd_strobe !== 1'b0) begin
      $display("Fail at %0d ns: %s outputs not idle in reset (pc %0d, wr %b, rd %b)",
               $time, tag, pc, port_wr_strobe, port_rd_strobe);
      errors++;
    end
  endtask

  task automatic run_row(input int r);
    int cyc;
    int n_seen;
    int n_rd;
    reset = 1'b1;
    for (int i = 0; i < 8; i++) begin // program loads while the cpu is held
      imem_we    = 1'b1;
      imem_addr  = `CPU_AW'(i);
      imem_wdata = prog[r][i];
      @(posedge clk);
      #1;
      check_idle(names[r]);
    end
    imem_we = 1'b0;
    reset   = 1'b0;
    cyc     = 0;
    n_seen  = 0;
    n_rd    = 0;
    while (n_seen < n_exp[r] && cyc < timeout_cycles) begin
      @(posedge clk);
      #1;
      cyc++;
      if (r == 0 && cyc <= 2 && pc !== `CPU_AW'(cyc)) begin // straight-line pc count
        $display("Fail at %0d ns: pc is %0d after %0d cycles", $time, pc, cyc);
        errors++;
      end
      if (port_rd_strobe) begin
        port_in = (n_rd < n_in[r]) ? pin[r][n_rd] : 16'h0;
        n_rd++;
      end
      if (port_wr_strobe) begin
        if (port_out !== exp_out[r][n_seen]) begin
          $display("Fail at %0d ns: %s port write %0d is %h, expected %h",
                   $time, names[r], n_seen, port_out, exp_out[r][n_seen]);
          errors++;
        end
        n_seen++;
      end
    end
    if (n_seen < n_exp[r]) begin
      $display("timeout: %s saw only %0d of %0d port writes in %0d cycles",
               names[r], n_seen, n_exp[r], cyc);
      timeouts++;
    end else if (n_rd != n_in[r]) begin
      $display("Fail at %0d ns: %s read the input port %0d times, expected %0d",
               $time, names[r], n_rd, n_in[r]);
      errors++;
    end
  endtask

  initial begin
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = 16'h0;
    port_in    = 16'h0;
    errors     = 0;
    timeouts   = 0;
    build_table();
    repeat (4) begin // power-up reset
      @(posedge clk);
      #1;
      check_idle("power-up");
    end
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("cpu_tb finished: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verif/tb_clock.sv */
// testbench clock source: free-running clock with a 10 ns period
module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

endmodule
